// File: dv/tb_soc.sv
`timescale 1ns/1ps

module tb_soc import bus_pkg::*; ();

    // Under 4k cycles of traffic, mostly SPI writes at about 70 cycles each
    localparam int TIMEOUT_CYCLES = 20000;

    logic   clk;
    logic   reset;
    addr_t  bus_addr;
    word_t  bus_wdata;
    wmask_t bus_wmask;
    logic   bus_wen;
    logic   bus_ren;
    word_t  bus_rdata;
    logic   bus_ready;
    word_t  io;
    logic   spi_sclk;
    logic   spi_cs;
    logic   spi_tx;
    logic   spi_rx;

    integer seed;
    int     cycle_count = 0;
    int     check_count;
    int     fail_count;
    int     test_fails;

    // Reference model of the address map
    word_t      mem_model [MEM_WORDS];
    word_t      pp_model;
    logic [7:0] spi_last;
    logic [7:0] spi_reply;

    // SPI device model state
    logic [7:0] dev_sr;
    logic [7:0] dev_cap;
    logic       rx_next;
    int         cs_falls;
    int         cs_rises;
    int         sclk_rises;

    soc_core DUT (
        .clk       (clk),
        .reset     (reset),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_wmask (bus_wmask),
        .bus_wen   (bus_wen),
        .bus_ren   (bus_ren),
        .bus_rdata (bus_rdata),
        .bus_ready (bus_ready),
        .io        (io),
        .spi_sclk  (spi_sclk),
        .spi_cs    (spi_cs),
        .spi_tx    (spi_tx),
        .spi_rx    (spi_rx)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped, no finish after %0d clock cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Device loads its reply MSB first when selected
    always @(negedge spi_cs) begin
        dev_sr  = spi_reply;
        rx_next = dev_sr[7];
        cs_falls++;
    end

    always @(posedge spi_cs) begin
        cs_rises++;
    end

    always @(posedge spi_sclk) begin
        if (spi_cs === 1'b0) begin
            dev_cap = {dev_cap[6:0], spi_tx};
            sclk_rises++;
        end
    end

    // Next reply bit goes out after each falling edge
    always @(negedge spi_sclk) begin
        if (spi_cs === 1'b0) begin
            dev_sr  = {dev_sr[6:0], 1'b0};
            rx_next = dev_sr[7];
        end
    end

    always @(posedge clk) begin
        spi_rx <= rx_next;
    end

    function automatic int region_of(input addr_t a);
        if (a[31:30] != 2'b00) begin
            return 3;
        end
        return int'(a[29:28]);
    endfunction

    // Unmapped picks either device code 3 or nonzero top bits
    function automatic addr_t pick_addr(input int region, input word_t r);
        if (region != 3) begin
            return {2'b00, 2'(region), r[27:0]};
        end
        if (r[0]) begin
            return {4'b0011, r[27:0]};
        end
        return {1'b1, r[30:0]};
    endfunction

    function automatic word_t expect_read(input addr_t a);
        case (region_of(a))
            0: return mem_model[a[11:2]];
            1: return pp_model;
            2: return {24'h0, spi_last};
            default: return '0;
        endcase
    endfunction

    task automatic model_write(input addr_t a, input word_t d, input wmask_t m);
        int region;
        region = region_of(a);
        for (int i = 0; i < 4; i++) begin
            if (m[i] && region == 0) begin
                mem_model[a[11:2]][i*8 +: 8] = d[i*8 +: 8];
            end
            if (m[i] && region == 1) begin
                pp_model[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        if (region == 2) begin
            spi_last = spi_reply;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            fail_count++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Drive one strobe and wait for bus_ready
    task automatic bus_access(input logic is_write, input addr_t addr, input word_t wdata,
                              input wmask_t wmask, output word_t rdata, output int latency);
        @(posedge clk);
        bus_addr  <= addr;
        bus_wdata <= wdata;
        bus_wmask <= wmask;
        bus_wen   <= is_write;
        bus_ren   <= !is_write;
        @(posedge clk);
        bus_wen <= 1'b0;
        bus_ren <= 1'b0;
        latency = 1;
        @(negedge clk);
        while (bus_ready !== 1'b1) begin
            @(negedge clk);
            latency++;
        end
        rdata = bus_rdata;
    endtask

    task automatic write_check(input addr_t a, input word_t d, input wmask_t m);
        word_t rd;
        int    lat;
        int    region;
        region = region_of(a);
        if (region == 2) begin
            spi_reply  = 8'($random(seed));
            cs_falls   = 0;
            cs_rises   = 0;
            sclk_rises = 0;
        end
        bus_access(1'b1, a, d, m, rd, lat);
        model_write(a, d, m);
        if (region == 2) begin
            check_word("spi_tx byte", {24'h0, dev_cap}, {24'h0, d[7:0]});
            check_word("spi_cs", {31'h0, spi_cs}, 32'h1);
            check_count++;
            if (cs_falls != 1 || cs_rises != 1 || sclk_rises != 8) begin
                fail_count++;
                $display("SPI transfer broken, chip select did not frame eight clocks");
            end
        end else begin
            check_word("bus_ready latency", 32'(lat), 32'h1);
        end
        if (region == 1) begin
            check_word("io", io, pp_model);
        end
    endtask

    task automatic read_check(input addr_t a);
        word_t rd;
        int    lat;
        bus_access(1'b0, a, '0, '0, rd, lat);
        check_word("bus_rdata", rd, expect_read(a));
        check_word("bus_ready latency", 32'(lat), 32'h1);
    endtask

    task automatic check_idle_pins();
        check_word("bus_ready", {31'h0, bus_ready}, 32'h0);
        check_word("spi_cs", {31'h0, spi_cs}, 32'h1);
        check_word("spi_sclk", {31'h0, spi_sclk}, 32'h0);
        check_word("io", io, 32'h0);
    endtask

    task automatic end_test(input string name);
        $display("Test %-12s finished with %0d errors", name, fail_count - test_fails);
        test_fails = fail_count;
    endtask

    initial begin
        addr_t a;
        int    region;
        seed        = 32646;
        clk         = 1'b0;
        reset       = 1'b1;
        bus_addr    = '0;
        bus_wdata   = '0;
        bus_wmask   = '0;
        bus_wen     = 1'b0;
        bus_ren     = 1'b0;
        spi_rx      = 1'b0;
        rx_next     = 1'b0;
        dev_sr      = '0;
        dev_cap     = '0;
        cs_falls    = 0;
        cs_rises    = 0;
        sclk_rises  = 0;
        pp_model    = '0;
        spi_last    = '0;
        spi_reply   = '0;
        check_count = 0;
        fail_count  = 0;
        test_fails  = 0;

        @(posedge clk);
        repeat (9) begin
            @(negedge clk);
            check_idle_pins();
        end
        @(posedge clk);
        reset <= 1'b0;
        // First look after the DUT has clocked with reset low
        repeat (2) @(negedge clk);
        check_idle_pins();
        end_test("reset");

        for (int i = 0; i < 200; i++) begin
            a = pick_addr(DEV_MEM, $random(seed));
            write_check(a, $random(seed), 4'($random(seed)));
            read_check(a);
        end
        end_test("memory");

        for (int i = 0; i < 50; i++) begin
            a = pick_addr(DEV_PP, $random(seed));
            write_check(a, $random(seed), 4'($random(seed)));
            read_check(a);
        end
        end_test("parallel");

        for (int i = 0; i < 20; i++) begin
            a = pick_addr(DEV_SPI, $random(seed));
            write_check(a, $random(seed), 4'($random(seed)));
            read_check(a);
        end
        end_test("spi");

        // Unmapped writes must not alias into memory or io
        for (int i = 0; i < 20; i++) begin
            a = pick_addr(3, $random(seed));
            read_check(a);
            write_check(a, $random(seed), 4'hf);
            read_check({20'h0, a[11:0]});
            read_check({4'b0001, a[27:0]});
            check_word("io", io, pp_model);
        end
        end_test("unmapped");

        for (int i = 0; i < 100; i++) begin
            region = int'(2'($random(seed)));
            a = pick_addr(region, $random(seed));
            if ($random(seed) & 1) begin
                write_check(a, $random(seed), 4'($random(seed)));
            end else begin
                read_check(a);
            end
        end
        end_test("interleaved");

        $display("Checks: %0d run, %0d passed, %0d failed",
                 check_count, check_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/bus_hub.sv
`timescale 1ns/1ps

module bus_hub import bus_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  addr_t  host_addr,
    input  word_t  host_wdata,
    input  wmask_t host_wmask,
    input  logic   host_wen,
    input  logic   host_ren,
    output word_t  host_rdata,
    output logic   host_ready,
    bus_if.host    mem_bus,
    bus_if.host    pp_bus,
    bus_if.host    spi_bus
);

    logic    strobe;
    logic    mapped;
    dev_id_t decode_dev;
    dev_id_t target;
    dev_id_t pend_dev;
    logic    busy;
    logic    nomap_ready;
    word_t   sel_rdata;
    logic    sel_ready;

    assign strobe     = host_wen | host_ren;
    assign decode_dev = host_addr[DEV_MSB:DEV_LSB];
    assign mapped     = (host_addr[31:DEV_MSB+1] == '0) && (decode_dev != DEV_NONE);
    assign target     = mapped ? decode_dev : DEV_NONE;

    // Address and write fields go to every device
    assign mem_bus.addr  = host_addr;
    assign mem_bus.wdata = host_wdata;
    assign mem_bus.wmask = host_wmask;
    assign pp_bus.addr   = host_addr;
    assign pp_bus.wdata  = host_wdata;
    assign pp_bus.wmask  = host_wmask;
    assign spi_bus.addr  = host_addr;
    assign spi_bus.wdata = host_wdata;
    assign spi_bus.wmask = host_wmask;

    // Strobes reach the decoded device only
    assign mem_bus.wen = host_wen && (target == DEV_MEM);
    assign mem_bus.ren = host_ren && (target == DEV_MEM);
    assign pp_bus.wen  = host_wen && (target == DEV_PP);
    assign pp_bus.ren  = host_ren && (target == DEV_PP);
    assign spi_bus.wen = host_wen && (target == DEV_SPI);
    assign spi_bus.ren = host_ren && (target == DEV_SPI);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            pend_dev    <= DEV_NONE;
            nomap_ready <= 1'b0;
        end else begin
            // Unmapped accesses are answered here one cycle later
            nomap_ready <= strobe && !mapped;
            if (strobe) begin
                busy     <= 1'b1;
                pend_dev <= target;
            end else if (host_ready) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        case (pend_dev)
            DEV_MEM: begin
                sel_rdata = mem_bus.rdata;
                sel_ready = mem_bus.ready;
            end
            DEV_PP: begin
                sel_rdata = pp_bus.rdata;
                sel_ready = pp_bus.ready;
            end
            DEV_SPI: begin
                sel_rdata = spi_bus.rdata;
                sel_ready = spi_bus.ready;
            end
            default: begin
                sel_rdata = '0;
                sel_ready = nomap_ready;
            end
        endcase
    end

    assign host_rdata = sel_rdata;
    assign host_ready = busy && sel_ready;

    // One host access at a time and never read and write together
    assert property (@(posedge clk) disable iff (reset) busy |-> !strobe);
    assert property (@(posedge clk) disable iff (reset) !(host_wen && host_ren));

endmodule

// File: rtl/bus_if.sv
`timescale 1ns/1ps

interface bus_if import bus_pkg::*; ();

    addr_t  addr;
    word_t  wdata;
    wmask_t wmask;
    logic   wen;
    logic   ren;
    word_t  rdata;
    logic   ready;

    // Hub side
    modport host (
        output addr, wdata, wmask, wen, ren,
        input  rdata, ready
    );

    // Peripheral side
    modport device (
        input  addr, wdata, wmask, wen, ren,
        output rdata, ready
    );

endinterface

// File: rtl/bus_pkg.sv
package bus_pkg;

    // Bus payload types
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Bit n enables byte lane n
    typedef logic [3:0] wmask_t;

    // Device select from addr[29:28]
    typedef logic [1:0] dev_id_t;

    localparam int DEV_LSB = 28;
    localparam int DEV_MSB = 29;

    // Address map
    localparam dev_id_t DEV_MEM  = 2'd0;
    localparam dev_id_t DEV_PP   = 2'd1;
    localparam dev_id_t DEV_SPI  = 2'd2;
    localparam dev_id_t DEV_NONE = 2'd3;

    // Block RAM geometry indexed by addr[11:2]
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW    = 10;

    typedef logic [MEM_AW-1:0] mem_idx_t;

    // Byte lanes per bus word
    localparam int BUS_LANES = $bits(wmask_t);

endpackage

// File: rtl/memory.sv
`timescale 1ns/1ps

module memory import bus_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    bus_if.device bus
);

    word_t    mem [MEM_WORDS];
    mem_idx_t idx;
    word_t    rdata_q;
    logic     ready_q;

    assign idx = bus.addr[MEM_AW+1:2];

    // Byte-lane writes and registered read
    always_ff @(posedge clk) begin
        if (bus.wen) begin
            for (int i = 0; i < BUS_LANES; i++) begin
                if (bus.wmask[i]) begin
                    mem[idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
                end
            end
        end
        if (bus.ren) begin
            rdata_q <= mem[idx];
        end
    end

    // Ack every access on the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= bus.wen | bus.ren;
        end
    end

    assign bus.rdata = rdata_q;
    assign bus.ready = ready_q;

    // No back-to-back acks
    assert property (@(posedge clk) disable iff (reset) bus.ready |=> !bus.ready);

endmodule

// File: rtl/parallel_output.sv
`timescale 1ns/1ps

module parallel_output import bus_pkg::*, periph_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    bus_if.device bus,
    output word_t io
);

    logic [PP_WIDTH-1:0] out_q;
    logic                ready_q;

    // Any address in the region hits the same register
    always_ff @(posedge clk) begin
        if (reset) begin
            out_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= bus.wen | bus.ren;
            if (bus.wen) begin
                for (int i = 0; i < PP_LANES; i++) begin
                    if (bus.wmask[i]) begin
                        out_q[i*8 +: 8] <= bus.wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

    // Readback of the pin state
    assign bus.rdata = out_q;
    assign bus.ready = ready_q;
    assign io        = out_q;

endmodule

// File: rtl/periph_pkg.sv
package periph_pkg;

    // SPI data byte
    typedef logic [7:0] spi_byte_t;

    // clk cycles per sclk half period
    localparam int SPI_CLK_DIV = 4;
    localparam int SPI_DIV_W   = $clog2(SPI_CLK_DIV);

    // Bits per transfer
    localparam int SPI_BITS  = $bits(spi_byte_t);
    localparam int SPI_BIT_W = $clog2(SPI_BITS);

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_DONE
    } spi_state_t;

    // Parallel output port
    localparam int PP_WIDTH = 32;
    localparam int PP_LANES = PP_WIDTH / 8;

endpackage

// File: rtl/soc_core.sv
`timescale 1ns/1ps

module soc_core import bus_pkg::*; (
    input  logic   clk,
    input  logic   reset,

    // Host bus
    input  addr_t  bus_addr,
    input  word_t  bus_wdata,
    input  wmask_t bus_wmask,
    input  logic   bus_wen,
    input  logic   bus_ren,
    output word_t  bus_rdata,
    output logic   bus_ready,

    // Parallel output pins
    output word_t  io,

    // SPI pins
    output logic   spi_sclk,
    output logic   spi_cs,
    output logic   spi_tx,
    input  logic   spi_rx
);

    bus_if mem_bus ();
    bus_if pp_bus ();
    bus_if spi_bus ();

    bus_hub hub (
        .clk        (clk),
        .reset      (reset),
        .host_addr  (bus_addr),
        .host_wdata (bus_wdata),
        .host_wmask (bus_wmask),
        .host_wen   (bus_wen),
        .host_ren   (bus_ren),
        .host_rdata (bus_rdata),
        .host_ready (bus_ready),
        .mem_bus    (mem_bus.host),
        .pp_bus     (pp_bus.host),
        .spi_bus    (spi_bus.host)
    );

    // Block RAM word memory
    memory mem (
        .clk   (clk),
        .reset (reset),
        .bus   (mem_bus.device)
    );

    parallel_output pp (
        .clk   (clk),
        .reset (reset),
        .bus   (pp_bus.device),
        .io    (io)
    );

    spi_controller spi (
        .clk     (clk),
        .reset   (reset),
        .bus     (spi_bus.device),
        .sclk    (spi_sclk),
        .cs      (spi_cs),
        .data_tx (spi_tx),
        .data_rx (spi_rx)
    );

endmodule

// File: rtl/spi_controller.sv
`timescale 1ns/1ps

module spi_controller import bus_pkg::*, periph_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    bus_if.device bus,
    output logic  sclk,
    output logic  cs,
    output logic  data_tx,
    input  logic  data_rx
);

    spi_state_t           state;
    logic [SPI_DIV_W-1:0] div_cnt;
    logic [SPI_BIT_W-1:0] bit_cnt;
    logic                 sclk_q;
    logic                 cs_q;
    logic                 tx_q;
    spi_byte_t            tx_shift;
    spi_byte_t            rx_shift;
    spi_byte_t            rx_byte;
    logic                 ready_q;
    logic                 half_done;

    // End of one sclk half period
    assign half_done = (div_cnt == SPI_DIV_W'(SPI_CLK_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= SPI_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk_q  <= 1'b0;
            cs_q    <= 1'b1;
            tx_q    <= 1'b0;
            rx_byte <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state)
                SPI_IDLE: begin
                    if (bus.wen) begin
                        // MSB goes out before the first rising edge
                        tx_q     <= bus.wdata[7];
                        tx_shift <= {bus.wdata[6:0], 1'b0};
                        cs_q     <= 1'b0;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        state    <= SPI_SHIFT;
                    end else if (bus.ren) begin
                        ready_q <= 1'b1;
                    end
                end
                SPI_SHIFT: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        sclk_q  <= !sclk_q;
                        if (!sclk_q) begin
                            // Rising edge samples the device
                            rx_shift <= {rx_shift[SPI_BITS-2:0], data_rx};
                        end else if (bit_cnt == SPI_BIT_W'(SPI_BITS - 1)) begin
                            state <= SPI_DONE;
                        end else begin
                            // Falling edge moves the next bit out
                            bit_cnt  <= bit_cnt + 1'b1;
                            tx_q     <= tx_shift[SPI_BITS-1];
                            tx_shift <= {tx_shift[SPI_BITS-2:0], 1'b0};
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                SPI_DONE: begin
                    cs_q    <= 1'b1;
                    tx_q    <= 1'b0;
                    rx_byte <= rx_shift;
                    ready_q <= 1'b1;
                    state   <= SPI_IDLE;
                end
                default: begin
                    state <= SPI_IDLE;
                end
            endcase
        end
    end

    assign sclk    = sclk_q;
    assign cs      = cs_q;
    assign data_tx = tx_q;

    // Last received byte zero-extended
    assign bus.rdata = {{($bits(word_t) - SPI_BITS){1'b0}}, rx_byte};
    assign bus.ready = ready_q;

    // Idle means deselected with sclk parked low
    assert property (@(posedge clk) disable iff (reset)
        (state == SPI_IDLE) |-> (cs_q && !sclk_q));

    // No access reaches the controller mid-transfer
    assert property (@(posedge clk) disable iff (reset)
        (state != SPI_IDLE) |-> !(bus.wen || bus.ren));

endmodule

// File: sources.f
rtl/bus_pkg.sv
rtl/periph_pkg.sv
rtl/bus_if.sv
rtl/memory.sv
rtl/parallel_output.sv
rtl/spi_controller.sv
rtl/bus_hub.sv
rtl/soc_core.sv
dv/tb_soc.sv
